//--- mmul_top.f
common/mmul_pkg.sv
rtl/mmul_regs.sv
rtl/mmul_ctrl.sv
engine/mmul_feeder.sv
engine/mmul_pe.sv
engine/mmul_collector.sv
rtl/mmul_top.sv
test/mmul_checker.sv
test/mmul_tb.sv

//--- Makefile
# Verilator build and run for the mmul testbench

VERILATOR ?= verilator
TOP       ?= mmul_tb
FILELIST  ?= mmul_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= Errors found
PASS_MSG  ?= No errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation failed"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "Simulation did not complete"; exit 1; \
	else \
	  echo "Simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- test/mmul_tb.sv
// Directed testbench for the mmul accelerator.
// Drives the register port and input beats of mmul_top, checks Z rows
// against a software model of Z = X * W and stops at the first mismatch.

`timescale 1ns/10ps

module mmul_tb;
  import mmul_pkg::*;

  localparam int unsigned NUM_PE  = 4;
  localparam int          TIMEOUT = 500;

  logic                         clk;
  logic                         rst_n;
  logic                         reg_we;
  logic                         reg_re;
  logic [REG_AW-1:0]            reg_addr;
  mmul_cfg_word_u               reg_wdata;
  logic [REG_DW-1:0]            reg_rdata;
  logic                         beat_valid;
  mmul_beat_t                   beat;
  logic                         z_valid;
  logic [NUM_PE-1:0][ACC_W-1:0] z_row;
  logic                         busy;
  logic                         done;

  // Operand store for the reference model
  logic [DATA_W-1:0] x_mem [8][8];
  logic [DATA_W-1:0] w_mem [8][NUM_PE];
  logic [31:0]       lfsr_q;
  int                z_cnt = 0;
  int                done_cnt = 0;

  mmul_top #(.NUM_PE(NUM_PE)) mmul_top_inst (
    .clk_i(clk), .rst_ni(rst_n), .reg_we_i(reg_we), .reg_re_i(reg_re),
    .reg_addr_i(reg_addr), .reg_wdata_i(reg_wdata), .reg_rdata_o(reg_rdata),
    .beat_valid_i(beat_valid), .beat_i(beat), .z_valid_o(z_valid), .z_row_o(z_row),
    .busy_o(busy), .done_o(done)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Pulse counters for the end-of-job checks
  always @(negedge clk) begin
    if (z_valid) begin
      z_cnt++;
    end
    if (done) begin
      done_cnt++;
    end
  end

  // Galois LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  task automatic check_equal(input logic [63:0] got, input logic [63:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
      $display("Errors found");
      $fatal(1, "Stopped on first mismatch");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout at %0t ns while waiting for %s", $time, what);
    $display("Errors found");
    $fatal(1, "Stopped on timeout");
  endtask

  task automatic reg_write(input logic [REG_AW-1:0] addr, input logic [31:0] data);
    @(negedge clk);
    reg_we    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(negedge clk);
    reg_we = 1'b0;
  endtask

  // Read data is back one cycle after the strobe
  task automatic reg_read(input logic [REG_AW-1:0] addr, output logic [31:0] data);
    @(negedge clk);
    reg_re   = 1'b1;
    reg_addr = addr;
    @(negedge clk);
    reg_re = 1'b0;
    data   = reg_rdata;
  endtask

  task automatic wait_busy(input logic level);
    int n;
    n = 0;
    while (busy !== level) begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) report_timeout("busy level");
    end
  endtask

  task automatic wait_done();
    int n;
    n = 0;
    while (done !== 1'b1) begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) report_timeout("done pulse");
    end
  endtask

  task automatic gen_operands(input int m, input int k);
    for (int i = 0; i < k; i++) begin
      for (int r = 0; r < m; r++) begin
        x_mem[r][i] = DATA_W'(rand_bits(DATA_W));
      end
      for (int c = 0; c < NUM_PE; c++) begin
        w_mem[i][c] = DATA_W'(rand_bits(DATA_W));
      end
    end
  endtask

  // Signed dot product of X row r and W column c, wrapping at 32 bits
  function automatic logic [ACC_W-1:0] ref_dot(input int r, input int c, input int k);
    logic signed [ACC_W-1:0] sum;
    sum = '0;
    for (int i = 0; i < k; i++) begin
      sum = sum + $signed(x_mem[r][i]) * $signed(w_mem[i][c]);
    end
    return sum;
  endfunction

  // Beats in row-major order, optional random gaps
  task automatic feed_beats(input int k, input int count, input bit gaps);
    int idx;
    idx = 0;
    while (idx < count) begin
      @(negedge clk);
      beat_valid = 1'b0;
      if (!gaps || rand_bits(2) != 0) begin
        beat_valid = 1'b1;
        beat.x     = x_mem[idx / k][idx % k];
        for (int c = 0; c < NUM_PE; c++) begin
          beat.w[c] = w_mem[idx % k][c];
        end
        idx++;
      end
    end
    @(negedge clk);
    beat_valid = 1'b0;
  endtask

  task automatic collect_rows(input int m, input int k);
    int row;
    int n;
    row = 0;
    n   = 0;
    while (row < m) begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) report_timeout("Z rows");
      if (z_valid) begin
        for (int c = 0; c < NUM_PE; c++) begin
          check_equal(z_row[c], ref_dot(row, c, k), $sformatf("Z[%0d][%0d]", row, c));
        end
        row++;
      end
    end
  endtask

  // Full job: program, start, stream, then check counts and status
  task automatic run_job(input int m, input int k, input bit gaps);
    int          z_start;
    int          done_start;
    logic [31:0] status;
    z_start    = z_cnt;
    done_start = done_cnt;
    reg_write(REG_DIMS, {DIM_W'(m), DIM_W'(k)});
    reg_write(REG_CMD, 32'h1);
    wait_busy(1'b1);
    // STARTING lasts one cycle, the first beat lands in COMPUTING
    fork
      feed_beats(k, m * k, gaps);
      collect_rows(m, k);
    join
    wait_done();
    repeat (4) @(negedge clk);
    check_equal(z_cnt - z_start, m, "Z row count");
    check_equal(done_cnt - done_start, 1, "done pulse count");
    reg_read(REG_STATUS, status);
    check_equal(status, 32'h4, "status after job");
  endtask

  task automatic test_reset();
    logic [31:0] status;
    reg_read(REG_STATUS, status);
    check_equal(status, 0, "status after reset");
    check_equal({busy, done, z_valid}, 0, "outputs after reset");
  endtask

  task automatic test_dims();
    logic [31:0] dims;
    logic [31:0] rd;
    dims = rand_bits(32);
    reg_write(REG_DIMS, dims);
    reg_read(REG_DIMS, rd);
    check_equal(rd, dims, "dims readback");
    // Zero M, then zero K
    reg_write(REG_DIMS, 32'h0000_0005);
    reg_write(REG_CMD, 32'h1);
    reg_read(REG_STATUS, rd);
    check_equal(rd, 32'h2, "status after start with M=0");
    reg_write(REG_DIMS, 32'h0003_0000);
    reg_write(REG_CMD, 32'h1);
    reg_read(REG_STATUS, rd);
    check_equal(rd, 32'h2, "status after start with K=0");
    check_equal(busy, 0, "busy after rejected start");
  endtask

  task automatic test_gaps();
    gen_operands(4, 3);
    run_job(4, 3, 1'b0);
    run_job(4, 3, 1'b1);
  endtask

  task automatic test_soft_clear();
    int          done_start;
    logic [31:0] status;
    gen_operands(4, 6);
    done_start = done_cnt;
    reg_write(REG_DIMS, {16'd4, 16'd6});
    reg_write(REG_CMD, 32'h1);
    wait_busy(1'b1);
    // One full row and half of the next
    feed_beats(6, 9, 1'b0);
    // Start clears sticky done and error so only busy is set
    reg_read(REG_STATUS, status);
    check_equal(status, 32'h1, "status during job");
    reg_write(REG_CMD, 32'h2);
    wait_busy(1'b0);
    repeat (4) @(negedge clk);
    check_equal(done_cnt - done_start, 0, "done after soft clear");
    gen_operands(2, 4);
    run_job(2, 4, 1'b0);
  endtask

  task automatic test_idle_beats();
    int z_start;
    z_start = z_cnt;
    gen_operands(3, 2);
    feed_beats(2, 6, 1'b0);
    repeat (4) @(negedge clk);
    check_equal(z_cnt - z_start, 0, "Z rows from idle beats");
    run_job(3, 2, 1'b1);
  endtask

  initial begin
    lfsr_q     = 32'h16f3_0168;
    rst_n      = 1'b0;
    reg_we     = 1'b0;
    reg_re     = 1'b0;
    reg_addr   = '0;
    reg_wdata  = '0;
    beat_valid = 1'b0;
    beat       = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    test_reset();
    test_dims();
    gen_operands(3, 5);
    run_job(3, 5, 1'b0);
    test_gaps();
    test_soft_clear();
    test_idle_beats();
    $display("No errors");
    $finish;
  end

endmodule : mmul_tb

//--- test/mmul_checker.sv
// Protocol assertions for the mmul top level.
// Bound into every mmul_top instance, watches status outputs and the
// internal start request of the register block.

`timescale 1ns/10ps

module mmul_checker (
  input logic clk_i,
  input logic rst_ni,
  input logic busy_i,
  input logic done_i,
  input logic z_valid_i,
  input logic start_req_i
);

  // Done belongs to FINISHED, never to a busy state
  done_not_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(done_i && busy_i))
    else $error("done_o high while busy_o is high");

  // Rows only come out during a job
  z_only_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    z_valid_i |-> busy_i)
    else $error("z_valid_o high while not busy");

  // FINISHED lasts one cycle
  done_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_i |=> !done_i)
    else $error("done_o longer than one cycle");

  // Starts while busy are dropped in the register block
  no_start_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(start_req_i && busy_i))
    else $error("start request while busy");

endmodule : mmul_checker

bind mmul_top mmul_checker mmul_checker_inst (
  .clk_i       ( clk_i     ),
  .rst_ni      ( rst_ni    ),
  .busy_i      ( busy_o    ),
  .done_i      ( done_o    ),
  .z_valid_i   ( z_valid_o ),
  .start_req_i ( start_req )
);

//--- rtl/mmul_top.sv
// Top level of the mmul accelerator, computing Z = X * W.
// Wires the register block and controller to the engine: feeder, a
// generate loop of NUM_PE PEs and the row collector.

`timescale 1ns/10ps

module mmul_top
  import mmul_pkg::*;
#(
  parameter int unsigned NUM_PE = 4
)(
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         reg_we_i,
  input  logic                         reg_re_i,
  input  logic [REG_AW-1:0]            reg_addr_i,
  input  mmul_cfg_word_u               reg_wdata_i,
  output logic [REG_DW-1:0]            reg_rdata_o,
  input  logic                         beat_valid_i,
  input  mmul_beat_t                   beat_i,
  output logic                         z_valid_o,
  output logic [NUM_PE-1:0][ACC_W-1:0] z_row_o,
  output logic                         busy_o,
  output logic                         done_o
);

  mmul_dims_t                   dims;
  mmul_ctrl_t                   ctrl;
  mmul_beat_t                   op;
  logic                         start_req;
  logic                         soft_clear;
  logic                         rows_done;
  logic                         op_valid;
  logic                         first;
  logic                         last;
  logic                         row_ready;
  logic [NUM_PE-1:0][ACC_W-1:0] acc;

  // Beat struct only has room for MAX_PE lanes
  if (NUM_PE < 1 || NUM_PE > MAX_PE) begin : g_num_pe_check
    $error("NUM_PE must be between 1 and MAX_PE");
  end

  mmul_regs i_regs (
    .clk_i, .rst_ni, .reg_we_i, .reg_re_i, .reg_addr_i, .reg_wdata_i, .reg_rdata_o,
    .busy_i       ( busy_o     ),
    .done_i       ( done_o     ),
    .dims_o       ( dims       ),
    .start_o      ( start_req  ),
    .soft_clear_o ( soft_clear )
  );

  mmul_ctrl i_ctrl (
    .clk_i, .rst_ni,
    .start_i      ( start_req  ),
    .soft_clear_i ( soft_clear ),
    .rows_done_i  ( rows_done  ),
    .ctrl_o       ( ctrl       ),
    .busy_o, .done_o
  );

  mmul_feeder #(.NUM_PE(NUM_PE)) i_feeder (
    .clk_i, .rst_ni, .beat_valid_i, .beat_i,
    .ctrl_i ( ctrl ), .dims_i ( dims ),
    .op_valid_o ( op_valid ), .op_o ( op ), .first_o ( first ), .last_o ( last )
  );

  // PE array, one Z column each
  for (genvar i = 0; i < NUM_PE; i++) begin : g_pe
    mmul_pe i_pe (
      .clk_i, .rst_ni,
      .clear_i    ( ctrl.clear ),
      .op_valid_i ( op_valid   ),
      .first_i    ( first      ),
      .x_i        ( op.x       ),
      .w_i        ( op.w[i]    ),
      .acc_o      ( acc[i]     )
    );
  end

  // Last beat delayed to line up with the PE accumulate edge
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      row_ready <= 1'b0;
    end else begin
      row_ready <= op_valid && last && !ctrl.clear;
    end
  end

  mmul_collector #(.NUM_PE(NUM_PE)) i_collector (
    .clk_i, .rst_ni, .z_valid_o, .z_row_o,
    .ctrl_i ( ctrl ), .dims_i ( dims ), .row_ready_i ( row_ready ),
    .acc_i  ( acc  ), .rows_done_o ( rows_done )
  );

endmodule : mmul_top

//--- engine/mmul_collector.sv
// Output stage of the mmul engine.
// Captures the PE accumulators when a row completes, presents them as a
// one-cycle Z row and counts rows against M. rows_done_o pulses with the
// last row of the job.

`timescale 1ns/10ps

module mmul_collector
  import mmul_pkg::*;
#(
  parameter int unsigned NUM_PE = 4
)(
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  mmul_ctrl_t                   ctrl_i,
  input  mmul_dims_t                   dims_i,
  input  logic                         row_ready_i,
  input  logic [NUM_PE-1:0][ACC_W-1:0] acc_i,
  output logic                         z_valid_o,
  output logic [NUM_PE-1:0][ACC_W-1:0] z_row_o,
  output logic                         rows_done_o
);

  logic [DIM_W-1:0] row_cnt_q;
  logic             row_last;

  assign row_last = (row_cnt_q == dims_i.m - DIM_W'(1));

  // Row counter and strobes
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      row_cnt_q   <= '0;
      z_valid_o   <= 1'b0;
      rows_done_o <= 1'b0;
    end else if (ctrl_i.clear || ctrl_i.first_load) begin
      row_cnt_q   <= '0;
      z_valid_o   <= 1'b0;
      rows_done_o <= 1'b0;
    end else begin
      z_valid_o   <= row_ready_i;
      rows_done_o <= row_ready_i && row_last;
      if (row_ready_i) begin
        row_cnt_q <= row_last ? '0 : row_cnt_q + DIM_W'(1);
      end
    end
  end

  // Row capture, before the next row's first beat overwrites the PEs
  always_ff @(posedge clk_i) begin
    if (row_ready_i) begin
      z_row_o <= acc_i;
    end
  end

endmodule : mmul_collector

//--- engine/mmul_pe.sv
// One multiply-accumulate PE of the mmul engine, owning one Z column.
// Multiplies signed X and W operands and accumulates, loading the bare
// product on the first beat of a row. The sum wraps at ACC_W bits.

`timescale 1ns/10ps

module mmul_pe
  import mmul_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     clear_i,
  input  logic                     op_valid_i,
  input  logic                     first_i,
  input  logic signed [DATA_W-1:0] x_i,
  input  logic signed [DATA_W-1:0] w_i,
  output logic        [ACC_W-1:0]  acc_o
);

  logic signed [ACC_W-1:0] prod;
  logic signed [ACC_W-1:0] acc_q;

  // Full product fits the accumulator width
  assign prod = ACC_W'(x_i * w_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q <= '0;
    end else if (clear_i) begin
      acc_q <= '0;
    end else if (op_valid_i) begin
      // Start a new row or keep summing
      acc_q <= first_i ? prod : acc_q + prod;
    end
  end

  assign acc_o = acc_q;

endmodule : mmul_pe

//--- engine/mmul_feeder.sv
// Input stage of the mmul engine.
// Accepts beats only while computing, registers them for the PE array
// and counts sampled beats against K to flag the first and last beat
// of every output row.

`timescale 1ns/10ps

module mmul_feeder
  import mmul_pkg::*;
#(
  parameter int unsigned NUM_PE = 4
)(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  mmul_ctrl_t ctrl_i,
  input  mmul_dims_t dims_i,
  input  logic       beat_valid_i,
  input  mmul_beat_t beat_i,
  output logic       op_valid_o,
  output mmul_beat_t op_o,
  output logic       first_o,
  output logic       last_o
);

  logic [DIM_W-1:0] k_cnt_q;
  logic             take;
  logic             k_last;
  mmul_beat_t       beat_m;

  // Beats outside COMPUTING are dropped
  assign take   = beat_valid_i && ctrl_i.computing && !ctrl_i.clear;
  assign k_last = (k_cnt_q == dims_i.k - DIM_W'(1));

  // Zero the W lanes that have no PE behind them
  always_comb begin
    beat_m.x = beat_i.x;
    for (int i = 0; i < MAX_PE; i++) begin
      beat_m.w[i] = (i < NUM_PE) ? beat_i.w[i] : '0;
    end
  end

  // K counter and flags
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      k_cnt_q    <= '0;
      op_valid_o <= 1'b0;
      first_o    <= 1'b0;
      last_o     <= 1'b0;
    end else if (ctrl_i.clear || ctrl_i.first_load) begin
      k_cnt_q    <= '0;
      op_valid_o <= 1'b0;
      first_o    <= 1'b0;
      last_o     <= 1'b0;
    end else begin
      op_valid_o <= take;
      if (take) begin
        first_o <= (k_cnt_q == '0);
        last_o  <= k_last;
        // Wrap at the end of a row
        k_cnt_q <= k_last ? '0 : k_cnt_q + DIM_W'(1);
      end
    end
  end

  // Operand register
  always_ff @(posedge clk_i) begin
    if (take) begin
      op_o <= beat_m;
    end
  end

endmodule : mmul_feeder

//--- rtl/mmul_ctrl.sv
// Controller FSM of the mmul subsystem.
// Sequences one job through IDLE, STARTING, COMPUTING and FINISHED and
// decodes busy, done and the engine job controls from the state.
// A soft clear sends the FSM back to IDLE at the next edge.

`timescale 1ns/10ps

module mmul_ctrl
  import mmul_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       start_i,
  input  logic       soft_clear_i,
  input  logic       rows_done_i,
  output mmul_ctrl_t ctrl_o,
  output logic       busy_o,
  output logic       done_o
);

  mmul_state_e state_q;
  mmul_state_e state_d;

  // State register
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= MMUL_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Next-state logic
  always_comb begin
    state_d = state_q;
    case (state_q)
      MMUL_IDLE: begin
        if (start_i) begin
          state_d = MMUL_STARTING;
        end
      end
      // One cycle for the engine counters to reload
      MMUL_STARTING: begin
        state_d = MMUL_COMPUTING;
      end
      // Leave once the collector has emitted M rows
      MMUL_COMPUTING: begin
        if (rows_done_i) begin
          state_d = MMUL_FINISHED;
        end
      end
      MMUL_FINISHED: begin
        state_d = MMUL_IDLE;
      end
      default: begin
        state_d = MMUL_IDLE;
      end
    endcase
    // Soft clear wins over any transition
    if (soft_clear_i) begin
      state_d = MMUL_IDLE;
    end
  end

  // Status decode
  assign busy_o = (state_q == MMUL_STARTING) || (state_q == MMUL_COMPUTING);
  assign done_o = (state_q == MMUL_FINISHED);

  // Engine controls
  assign ctrl_o.first_load = (state_q == MMUL_STARTING);
  assign ctrl_o.computing  = (state_q == MMUL_COMPUTING);
  // Flush the engine at the end of a job or on soft clear
  assign ctrl_o.clear      = soft_clear_i || (state_q == MMUL_FINISHED);

endmodule : mmul_ctrl

//--- rtl/mmul_regs.sv
// Register block of the mmul subsystem.
// Decodes command and dimension writes, latches and validates the job
// dimensions on start, and answers status reads one cycle after the read.

`timescale 1ns/10ps

module mmul_regs
  import mmul_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  reg_we_i,
  input  logic                  reg_re_i,
  input  logic [REG_AW-1:0]     reg_addr_i,
  input  mmul_cfg_word_u        reg_wdata_i,
  output logic [REG_DW-1:0]     reg_rdata_o,
  input  logic                  busy_i,
  input  logic                  done_i,
  output mmul_dims_t            dims_o,
  output logic                  start_o,
  output logic                  soft_clear_o
);

  mmul_dims_t dims_q;
  logic       err_q;
  logic       done_q;
  logic       cmd_we;
  logic       start_cmd;
  logic       dims_ok;
  logic       start_ok;
  logic       start_bad;

  // Command write decode
  assign cmd_we    = reg_we_i && (reg_addr_i == REG_CMD);
  // A start is dropped while a job runs or its start pulse is pending
  assign start_cmd = cmd_we && reg_wdata_i.cmd.start && !reg_wdata_i.cmd.soft_clear &&
                     !busy_i && !start_o;
  assign dims_ok   = (dims_q.m != '0) && (dims_q.k != '0);
  assign start_ok  = start_cmd && dims_ok;
  assign start_bad = start_cmd && !dims_ok;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dims_q       <= '0;
      dims_o       <= '0;
      err_q        <= 1'b0;
      done_q       <= 1'b0;
      start_o      <= 1'b0;
      soft_clear_o <= 1'b0;
    end else begin
      start_o      <= start_ok;
      soft_clear_o <= cmd_we && reg_wdata_i.cmd.soft_clear;
      // Programmed dimensions, free to change during a job
      if (reg_we_i && (reg_addr_i == REG_DIMS)) begin
        dims_q <= reg_wdata_i.dims;
      end
      // Sticky done from the controller
      if (done_i) begin
        done_q <= 1'b1;
      end
      // Job copy of the dimensions taken on a valid start
      if (start_ok) begin
        dims_o <= dims_q;
        err_q  <= 1'b0;
        done_q <= 1'b0;
      end else if (start_bad) begin
        err_q <= 1'b1;
      end
    end
  end

  // Read data, one cycle after the strobe
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      reg_rdata_o <= '0;
    end else if (reg_re_i) begin
      case (reg_addr_i)
        REG_DIMS:   reg_rdata_o <= dims_q;
        REG_STATUS: reg_rdata_o <= {{(REG_DW-3){1'b0}}, done_q, err_q, busy_i};
        default:    reg_rdata_o <= '0;
      endcase
    end
  end

endmodule : mmul_regs

//--- common/mmul_pkg.sv
// Shared definitions for the mmul matrix-multiply subsystem.
// Holds datapath widths, register map, the write-word union, the beat
// and control structs and the controller state encoding.
// Every mmul module pulls these in with a wildcard import in its header.

package mmul_pkg;

  // Datapath widths
  localparam int unsigned DATA_W = 16;
  localparam int unsigned ACC_W  = 32;
  localparam int unsigned DIM_W  = 16;

  // Upper bound on the PE count, sizes the beat struct
  localparam int unsigned MAX_PE = 4;

  // Register port
  localparam int unsigned REG_AW = 2;
  localparam int unsigned REG_DW = 32;

  localparam logic [REG_AW-1:0] REG_CMD    = 2'd0;
  localparam logic [REG_AW-1:0] REG_DIMS   = 2'd1;
  localparam logic [REG_AW-1:0] REG_STATUS = 2'd2;

  // Job dimensions, M rows of X and inner dimension K
  typedef struct packed {
    logic [DIM_W-1:0] m;
    logic [DIM_W-1:0] k;
  } mmul_dims_t;

  // Command view of the write word
  typedef struct packed {
    logic [REG_DW-3:0] rsvd;
    logic              soft_clear;
    logic              start;
  } mmul_cmd_t;

  // One write word, decoded by address as a command or as dimensions
  typedef union packed {
    mmul_cmd_t  cmd;
    mmul_dims_t dims;
  } mmul_cfg_word_u;

  // Job controls from the controller to the engine
  typedef struct packed {
    logic clear;
    logic first_load;
    logic computing;
  } mmul_ctrl_t;

  // One input beat: an X element and one W row slice
  typedef struct packed {
    logic [DATA_W-1:0]             x;
    logic [MAX_PE-1:0][DATA_W-1:0] w;
  } mmul_beat_t;

  // Controller states
  typedef enum logic [1:0] {
    MMUL_IDLE,
    MMUL_STARTING,
    MMUL_COMPUTING,
    MMUL_FINISHED
  } mmul_state_e;

endpackage : mmul_pkg
